/* include/kbd_defines.svh */
`ifndef KBD_DEFINES_SVH
`define KBD_DEFINES_SVH

////////////////////
// CPU bus decode
////////////////////

// Upper 12 address bits of the key port page, FD30..FD3F
`define KEYPORT_PAGE 12'hFD3

////////////////////
// PS/2 receiver
////////////////////

// Samples of a steady PS/2 clock level before an edge is taken
`define PS2_FILT_LEN 4

// Prefix bytes of scancode set 2
`define PS2_BREAK 8'hF0
`define PS2_EXT   8'hE0

`endif

/* design/kbd_pkg.sv */
package kbd_pkg;

	////////////////////
	// Plain vector types
	////////////////////

	// One PS/2 scancode byte
	typedef logic [7:0] scancode_t;
	// One bit per matrix row, active low as a row select
	typedef logic [7:0] key_row_t;
	// One bit per matrix column, active low on kbus
	typedef logic [7:0] key_col_t;
	// Pressed keys, indexed [row][col], 1 means pressed
	typedef logic [7:0][7:0] key_matrix_t;
	// Joystick pins, active low
	// Bit 0 up, 1 down, 2 left, 3 right, 4 fire
	typedef logic [4:0] joy_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;

	////////////////////
	// Bundles
	////////////////////

	// One CPU access, stb lasts a single cycle
	typedef struct packed {
		logic      stb;
		logic      rw;
		cpu_addr_t addr;
		cpu_data_t wdata;
	} cpu_bus_t;

	// Scancode offer, ack runs back on its own wire
	typedef struct packed {
		logic      req;
		scancode_t code;
	} scan_hs_t;

	// Matrix position of a key
	typedef struct packed {
		logic       valid;
		logic [2:0] row;
		logic [2:0] col;
	} key_pos_t;

	typedef enum logic [1:0] {IDLE, SHIFT, OFFER, RELEASE} ps2_state_e;
	typedef enum logic {WAIT_REQ, WAIT_DROP} keym_state_e;

	////////////////////
	// Scancode set 2 to C16 matrix
	////////////////////

	function automatic key_pos_t key_lookup(input logic ext, input scancode_t code);
		key_pos_t pos;
		pos = '0;
		case ({ext, code})
			// Row 0, INST/DEL on E0 71 and RETURN
			9'h171: pos = '{1'b1, 3'd0, 3'd0};
			9'h05A: pos = '{1'b1, 3'd0, 3'd1};
			// Row 1, 3 W A 4 Z S E SHIFT
			9'h026: pos = '{1'b1, 3'd1, 3'd0};
			9'h01D: pos = '{1'b1, 3'd1, 3'd1};
			9'h01C: pos = '{1'b1, 3'd1, 3'd2};
			9'h025: pos = '{1'b1, 3'd1, 3'd3};
			9'h01A: pos = '{1'b1, 3'd1, 3'd4};
			9'h01B: pos = '{1'b1, 3'd1, 3'd5};
			9'h024: pos = '{1'b1, 3'd1, 3'd6};
			9'h012: pos = '{1'b1, 3'd1, 3'd7};
			9'h059: pos = '{1'b1, 3'd1, 3'd7};
			// Row 2, 5 R D 6 C F T X
			9'h02E: pos = '{1'b1, 3'd2, 3'd0};
			9'h02D: pos = '{1'b1, 3'd2, 3'd1};
			9'h023: pos = '{1'b1, 3'd2, 3'd2};
			9'h036: pos = '{1'b1, 3'd2, 3'd3};
			9'h021: pos = '{1'b1, 3'd2, 3'd4};
			9'h02B: pos = '{1'b1, 3'd2, 3'd5};
			9'h02C: pos = '{1'b1, 3'd2, 3'd6};
			9'h022: pos = '{1'b1, 3'd2, 3'd7};
			// Row 3, 7 Y G 8 B H U V
			9'h03D: pos = '{1'b1, 3'd3, 3'd0};
			9'h035: pos = '{1'b1, 3'd3, 3'd1};
			9'h034: pos = '{1'b1, 3'd3, 3'd2};
			9'h03E: pos = '{1'b1, 3'd3, 3'd3};
			9'h032: pos = '{1'b1, 3'd3, 3'd4};
			9'h033: pos = '{1'b1, 3'd3, 3'd5};
			9'h03C: pos = '{1'b1, 3'd3, 3'd6};
			9'h02A: pos = '{1'b1, 3'd3, 3'd7};
			// Row 4, 9 I J 0 M K O N
			9'h046: pos = '{1'b1, 3'd4, 3'd0};
			9'h043: pos = '{1'b1, 3'd4, 3'd1};
			9'h03B: pos = '{1'b1, 3'd4, 3'd2};
			9'h045: pos = '{1'b1, 3'd4, 3'd3};
			9'h03A: pos = '{1'b1, 3'd4, 3'd4};
			9'h042: pos = '{1'b1, 3'd4, 3'd5};
			9'h044: pos = '{1'b1, 3'd4, 3'd6};
			9'h031: pos = '{1'b1, 3'd4, 3'd7};
			// Row 5, P L
			9'h04D: pos = '{1'b1, 3'd5, 3'd1};
			9'h04B: pos = '{1'b1, 3'd5, 3'd2};
			// Row 7, 1 CTRL(Alt) 2 SPACE C=(Ctrl) Q
			9'h016: pos = '{1'b1, 3'd7, 3'd0};
			9'h011: pos = '{1'b1, 3'd7, 3'd2};
			9'h111: pos = '{1'b1, 3'd7, 3'd2};
			9'h01E: pos = '{1'b1, 3'd7, 3'd3};
			9'h029: pos = '{1'b1, 3'd7, 3'd4};
			9'h014: pos = '{1'b1, 3'd7, 3'd5};
			9'h114: pos = '{1'b1, 3'd7, 3'd5};
			9'h015: pos = '{1'b1, 3'd7, 3'd6};
			default: pos = '0;
		endcase
		return pos;
	endfunction

endpackage

/* design/ps2_frame_rx.sv */
`timescale 1ns/1ps
`include "kbd_defines.svh"

module ps2_frame_rx (
	input  logic              CLK28,
	input  logic              rst_n,
	input  logic              ps2_clk,
	input  logic              ps2_dat,
	input  logic              scan_ack,
	output kbd_pkg::scan_hs_t scan
);
	import kbd_pkg::*;

	// Two flop synchronisers, lines idle high
	logic [1:0] clk_sync;
	logic [1:0] dat_sync;
	// Older clock samples, the newest sample is clk_sync[1]
	logic [`PS2_FILT_LEN-2:0] clk_hist;
	logic clk_filt;
	logic fall;
	logic [3:0] bit_cnt;
	logic [10:0] frame_sr;
	logic [10:0] frame_next;
	logic frame_done;
	logic frame_ok;
	logic start_seen;
	ps2_state_e state;
	scancode_t code_q;

	////////////////////
	// Line conditioning
	////////////////////

	// Falling edge once the whole window reads low
	assign fall = clk_filt && (clk_hist == '0) && !clk_sync[1];

	always_ff @(posedge CLK28) begin
		if (!rst_n) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
			clk_hist <= '1;
			clk_filt <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			dat_sync <= {dat_sync[0], ps2_dat};
			clk_hist <= {clk_hist[`PS2_FILT_LEN-3:0], clk_sync[1]};
			// Back high only after a full window of ones
			if (fall)
				clk_filt <= 1'b0;
			else if ((&clk_hist) && clk_sync[1])
				clk_filt <= 1'b1;
		end
	end

	////////////////////
	// Frame assembly
	////////////////////

	// Bits arrive LSB first, start ends up in bit 0
	assign frame_next = {dat_sync[1], frame_sr[10:1]};
	assign start_seen = fall && (bit_cnt == 4'd0) && !dat_sync[1];
	assign frame_done = fall && (bit_cnt == 4'd10);
	// Start low, stop high, odd parity over data and parity bit
	assign frame_ok = !frame_next[0] && frame_next[10] && (^frame_next[9:1]);

	always_ff @(posedge CLK28) begin
		if (!rst_n) begin
			bit_cnt <= 4'd0;
		end else if (fall) begin
			if (bit_cnt == 4'd0)
				bit_cnt <= start_seen ? 4'd1 : 4'd0;
			else if (bit_cnt == 4'd10)
				bit_cnt <= 4'd0;
			else
				bit_cnt <= bit_cnt + 4'd1;
		end
	end

	always_ff @(posedge CLK28) begin
		if (fall)
			frame_sr <= frame_next;
		if ((state == SHIFT) && frame_done && frame_ok)
			code_q <= frame_next[8:1];
	end

	////////////////////
	// Handshake FSM
	////////////////////

	always_ff @(posedge CLK28) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				// Frames started during a handshake are never taken
				IDLE: if (start_seen) state <= SHIFT;
				SHIFT: if (frame_done) state <= frame_ok ? OFFER : IDLE;
				OFFER: if (scan_ack) state <= RELEASE;
				RELEASE: if (!scan_ack) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign scan.req  = (state == OFFER);
	assign scan.code = code_q;

	// Offered code holds until the matrix has it
	a_code_stable: assert property (@(posedge CLK28) disable iff (!rst_n)
		scan.req |=> !scan.req || $stable(scan.code));

	// Request is withdrawn only after the matrix acknowledged
	a_req_fall: assert property (@(posedge CLK28) disable iff (!rst_n)
		$fell(scan.req) |-> $past(scan_ack));

endmodule

/* design/key_matrix.sv */
`timescale 1ns/1ps
`include "kbd_defines.svh"

module key_matrix (
	input  logic                 CLK28,
	input  logic                 rst_n,
	input  kbd_pkg::scan_hs_t    scan,
	output logic                 scan_ack,
	output kbd_pkg::key_matrix_t matrix,
	output logic                 key_reset
);
	import kbd_pkg::*;

	keym_state_e state;
	logic accept;
	// Prefix flags, live until the next real key code
	logic brk_q;
	logic ext_q;
	logic brk_next;
	logic ext_next;
	key_pos_t pos;
	key_matrix_t matrix_next;
	logic key_reset_next;
	// Positions of the reset chord keys
	key_pos_t pos_ctrl;
	key_pos_t pos_cbm;
	key_pos_t pos_del;

	////////////////////
	// Handshake side
	////////////////////

	// Take the code on the first cycle req is seen
	assign accept = (state == WAIT_REQ) && scan.req;

	always_ff @(posedge CLK28) begin
		if (!rst_n) begin
			state <= WAIT_REQ;
		end else begin
			case (state)
				WAIT_REQ: if (scan.req) state <= WAIT_DROP;
				WAIT_DROP: if (!scan.req) state <= WAIT_REQ;
				default: state <= WAIT_REQ;
			endcase
		end
	end

	// Ack is high for the whole drop wait
	assign scan_ack = (state == WAIT_DROP);

	////////////////////
	// Code decode
	////////////////////

	// Chord keys taken from the same table as the rest
	// Alt acts as CTRL, Ctrl acts as C=
	assign pos_ctrl = key_lookup(1'b0, 8'h11);
	assign pos_cbm  = key_lookup(1'b0, 8'h14);
	assign pos_del  = key_lookup(1'b1, 8'h71);

	assign pos = key_lookup(ext_q, scan.code);

	always_comb begin
		matrix_next = matrix;
		brk_next = brk_q;
		ext_next = ext_q;
		if (accept) begin
			if (scan.code == `PS2_BREAK) begin
				brk_next = 1'b1;
			end else if (scan.code == `PS2_EXT) begin
				ext_next = 1'b1;
			end else begin
				// Unmapped codes only consume the prefixes
				if (pos.valid)
					matrix_next[pos.row][pos.col] = !brk_q;
				brk_next = 1'b0;
				ext_next = 1'b0;
			end
		end
	end

	// CTRL + C= + DEL all held
	assign key_reset_next = matrix_next[pos_ctrl.row][pos_ctrl.col]
		& matrix_next[pos_cbm.row][pos_cbm.col]
		& matrix_next[pos_del.row][pos_del.col];

	////////////////////
	// State registers
	////////////////////

	always_ff @(posedge CLK28) begin
		if (!rst_n) begin
			brk_q <= 1'b0;
			ext_q <= 1'b0;
			matrix <= '0;
			key_reset <= 1'b0;
		end else begin
			brk_q <= brk_next;
			ext_q <= ext_next;
			// Matrix and chord flag move together
			matrix <= matrix_next;
			key_reset <= key_reset_next;
		end
	end

	// Ack answers a live request from the receiver
	a_ack_rise: assert property (@(posedge CLK28) disable iff (!rst_n)
		$rose(scan_ack) |-> scan.req);

endmodule

/* design/key_port.sv */
`timescale 1ns/1ps
`include "kbd_defines.svh"

module key_port (
	input  logic               CLK28,
	input  logic               rst_n,
	input  kbd_pkg::cpu_bus_t  bus,
	output kbd_pkg::cpu_data_t rdata,
	output logic               rvalid,
	output kbd_pkg::key_row_t  row_sel
);

	logic page_hit;
	logic wr_stb;
	logic rd_stb;

	////////////////////
	// Address decode
	////////////////////

	// Whole 16 byte page mirrors the one register
	assign page_hit = (bus.addr[15:4] == `KEYPORT_PAGE);
	assign wr_stb = bus.stb && !bus.rw && page_hit;
	assign rd_stb = bus.stb && bus.rw;

	////////////////////
	// Row latch
	////////////////////

	always_ff @(posedge CLK28) begin
		if (!rst_n) begin
			// All rows deselected
			row_sel <= 8'hFF;
			rvalid <= 1'b0;
		end else begin
			if (wr_stb)
				row_sel <= bus.wdata;
			// Every read is answered, mapped or not
			rvalid <= rd_stb;
		end
	end

	// Port is output only, a read sees the latch itself
	always_ff @(posedge CLK28) begin
		if (rd_stb)
			rdata <= page_hit ? row_sel : 8'hFF;
	end

endmodule

/* design/kbus_drive.sv */
`timescale 1ns/1ps

module kbus_drive (
	input  logic                 CLK28,
	input  logic                 rst_n,
	input  kbd_pkg::key_matrix_t matrix,
	input  kbd_pkg::key_row_t    row_sel,
	input  kbd_pkg::joy_t        joy0,
	input  kbd_pkg::joy_t        joy1,
	input  logic [1:0]           joy_sel_n,
	output kbd_pkg::key_col_t    kbus
);
	import kbd_pkg::*;

	key_col_t pressed;
	key_col_t kbd_col;
	key_col_t joy_col;
	key_col_t kbus_next;
	joy_t joy0_eff;
	joy_t joy1_eff;

	////////////////////
	// Keyboard columns
	////////////////////

	// OR of all pressed keys in the selected rows
	always_comb begin
		pressed = '0;
		for (int r = 0; r < 8; r++) begin
			if (!row_sel[r])
				pressed = pressed | matrix[r];
		end
	end

	assign kbd_col = ~pressed;

	////////////////////
	// Joystick merge
	////////////////////

	// Disabled stick floats high
	assign joy0_eff = joy_sel_n[0] ? 5'h1F : joy0;
	assign joy1_eff = joy_sel_n[1] ? 5'h1F : joy1;

	// Directions share columns 0..3, fire buttons on 6 and 7
	assign joy_col = {joy1_eff[4], joy0_eff[4], 2'b11, joy0_eff[3:0] & joy1_eff[3:0]};

	assign kbus_next = kbd_col & joy_col;

	always_ff @(posedge CLK28) begin
		if (!rst_n)
			kbus <= 8'hFF;
		else
			kbus <= kbus_next;
	end

endmodule

/* design/kbd_top.sv */
`timescale 1ns/1ps

module kbd_top (
	input  logic               CLK28,
	input  logic               rst_n,
	input  logic               ps2_clk,
	input  logic               ps2_dat,
	input  kbd_pkg::cpu_bus_t  bus,
	input  kbd_pkg::joy_t      joy0,
	input  kbd_pkg::joy_t      joy1,
	input  logic [1:0]         joy_sel_n,
	output kbd_pkg::cpu_data_t rdata,
	output logic               rvalid,
	output kbd_pkg::key_col_t  kbus,
	output logic               key_reset
);
	import kbd_pkg::*;

	// Receiver to matrix handshake
	scan_hs_t scan;
	logic scan_ack;
	// Matrix and row select into the column bus
	key_matrix_t matrix;
	key_row_t row_sel;

	////////////////////
	// Input side
	////////////////////

	ps2_frame_rx ps2_frame_rx_inst (
		.CLK28    (CLK28),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_dat  (ps2_dat),
		.scan_ack (scan_ack),
		.scan     (scan)
	);

	key_matrix key_matrix_inst (
		.CLK28     (CLK28),
		.rst_n     (rst_n),
		.scan      (scan),
		.scan_ack  (scan_ack),
		.matrix    (matrix),
		.key_reset (key_reset)
	);

	////////////////////
	// CPU side
	////////////////////

	key_port key_port_inst (
		.CLK28   (CLK28),
		.rst_n   (rst_n),
		.bus     (bus),
		.rdata   (rdata),
		.rvalid  (rvalid),
		.row_sel (row_sel)
	);

	// Column bus as the video chip samples it
	kbus_drive kbus_drive_inst (
		.CLK28     (CLK28),
		.rst_n     (rst_n),
		.matrix    (matrix),
		.row_sel   (row_sel),
		.joy0      (joy0),
		.joy1      (joy1),
		.joy_sel_n (joy_sel_n),
		.kbus      (kbus)
	);

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
	output logic CLK28,
	output logic rst_n
);

	// 8 ns period stands in for the fabric clock
	initial begin
		CLK28 = 1'b0;
		forever #4 CLK28 = ~CLK28;
	end

	// Reset low over the first three rising edges
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge CLK28);
		rst_n <= 1'b1;
	end

endmodule

/* tb/kbd_tb.sv */
`timescale 1ns/1ps
`include "kbd_defines.svh"

module kbd_tb;
	import kbd_pkg::*;

	// 40 us PS/2 bit is 5000 cycles, split in quarters
	localparam int QUARTER_BIT = 1250;
	localparam int HS_TIMEOUT = 20000;
	localparam int NUM_KEYS = 12;

	// Where a key sits on the C16 matrix
	typedef struct packed {
		scancode_t  code;
		logic [2:0] row;
		logic [2:0] col;
	} key_ref_t;

	logic CLK28;
	logic rst_n;
	logic ps2_clk;
	logic ps2_dat;
	cpu_bus_t bus;
	joy_t joy0;
	joy_t joy1;
	logic [1:0] joy_sel_n;
	cpu_data_t rdata;
	logic rvalid;
	key_col_t kbus;
	logic key_reset;

	integer seed;
	int fail_cnt = 0;
	// Handshake edges seen inside the DUT
	int req_cnt;
	int ack_cnt;
	logic req_d;
	logic ack_d;
	// Last byte written to the key port page
	cpu_data_t row_model;
	key_ref_t key_tab [NUM_KEYS];

	tb_clk_gen tb_clk_gen_inst (
		.CLK28 (CLK28),
		.rst_n (rst_n)
	);

	kbd_top kbd_top_inst (
		.CLK28     (CLK28),
		.rst_n     (rst_n),
		.ps2_clk   (ps2_clk),
		.ps2_dat   (ps2_dat),
		.bus       (bus),
		.joy0      (joy0),
		.joy1      (joy1),
		.joy_sel_n (joy_sel_n),
		.rdata     (rdata),
		.rvalid    (rvalid),
		.kbus      (kbus),
		.key_reset (key_reset)
	);

	////////////////////
	// Failure reports
	////////////////////

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
		fail_cnt++;
		$display("[ERROR] %s expected 0x%0h got 0x%0h", name, exp, got);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic timeout_error(input string what);
		fail_cnt++;
		$display("Timeout: %s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got == exp) else value_error(name, exp, got);
	endtask

	////////////////////
	// Monitors and bus checks
	////////////////////

	always_ff @(posedge CLK28) begin
		if (!rst_n) begin
			req_d <= 1'b0;
			ack_d <= 1'b0;
			req_cnt <= 0;
			ack_cnt <= 0;
		end else begin
			req_d <= kbd_top_inst.scan.req;
			ack_d <= kbd_top_inst.scan_ack;
			if (kbd_top_inst.scan.req && !req_d)
				req_cnt <= req_cnt + 1;
			if (kbd_top_inst.scan_ack && !ack_d)
				ack_cnt <= ack_cnt + 1;
		end
	end

	// Write anywhere in FD3x lands in the row latch
	always_ff @(posedge CLK28) begin
		if (!rst_n)
			row_model <= 8'hFF;
		else if (bus.stb && !bus.rw && (bus.addr[15:4] == `KEYPORT_PAGE))
			row_model <= bus.wdata;
	end

	a_rvalid_read: assert property (@(posedge CLK28) disable iff (!rst_n)
		(bus.stb && bus.rw) |=> rvalid)
		else value_error("rvalid", 1, rvalid);

	a_rvalid_quiet: assert property (@(posedge CLK28) disable iff (!rst_n)
		!(bus.stb && bus.rw) |=> !rvalid)
		else value_error("rvalid", 0, rvalid);

	// Own page reads back the latch, any other page reads FF
	a_rdata_page: assert property (@(posedge CLK28) disable iff (!rst_n)
		(bus.stb && bus.rw && (bus.addr[15:4] == `KEYPORT_PAGE)) |=> (rdata == row_model))
		else value_error("rdata", row_model, rdata);

	a_rdata_other: assert property (@(posedge CLK28) disable iff (!rst_n)
		(bus.stb && bus.rw && (bus.addr[15:4] != `KEYPORT_PAGE)) |=> (rdata == 8'hFF))
		else value_error("rdata", 8'hFF, rdata);

	////////////////////
	// Stimulus
	////////////////////

	// Start, data LSB first, odd parity, stop
	task automatic send_frame(input scancode_t code, input logic bad_par);
		logic [10:0] frame;
		int req_before;
		int ack_before;
		int n;
		req_before = req_cnt;
		ack_before = ack_cnt;
		frame = {1'b1, ~(^code) ^ bad_par, code, 1'b0};
		@(posedge CLK28);
		for (int i = 0; i < 11; i++) begin
			// Data moves while the keyboard clock is high
			ps2_dat <= frame[i];
			repeat (QUARTER_BIT) @(posedge CLK28);
			ps2_clk <= 1'b0;
			repeat (2 * QUARTER_BIT) @(posedge CLK28);
			ps2_clk <= 1'b1;
			repeat (QUARTER_BIT) @(posedge CLK28);
		end
		ps2_dat <= 1'b1;
		n = 0;
		if (bad_par) begin
			// No offer within the frame plus a margin
			while ((req_cnt == req_before) && (n < HS_TIMEOUT)) begin
				@(posedge CLK28);
				n++;
			end
			if (req_cnt != req_before)
				value_error("req count", req_before, req_cnt);
		end else begin
			while ((ack_cnt == ack_before) && (n < HS_TIMEOUT)) begin
				@(posedge CLK28);
				n++;
			end
			if (ack_cnt == ack_before)
				timeout_error("scancode was never acknowledged");
			n = 0;
			while ((kbd_top_inst.scan.req || kbd_top_inst.scan_ack) && (n < HS_TIMEOUT)) begin
				@(posedge CLK28);
				n++;
			end
			if (kbd_top_inst.scan.req || kbd_top_inst.scan_ack)
				timeout_error("req/ack handshake did not return to idle");
		end
	endtask

	// Make or break of one key, E0 goes first
	task automatic key_event(input logic ext, input logic brk, input scancode_t code);
		if (ext)
			send_frame(`PS2_EXT, 1'b0);
		if (brk)
			send_frame(`PS2_BREAK, 1'b0);
		send_frame(code, 1'b0);
	endtask

	task automatic cpu_write(input cpu_addr_t addr, input cpu_data_t data);
		@(posedge CLK28);
		bus <= '{stb: 1'b1, rw: 1'b0, addr: addr, wdata: data};
		@(posedge CLK28);
		bus.stb <= 1'b0;
	endtask

	task automatic cpu_read(input cpu_addr_t addr, output cpu_data_t data);
		int n;
		@(posedge CLK28);
		bus <= '{stb: 1'b1, rw: 1'b1, addr: addr, wdata: 8'h00};
		@(posedge CLK28);
		bus.stb <= 1'b0;
		n = 0;
		@(negedge CLK28);
		while (!rvalid && (n < 16)) begin
			@(negedge CLK28);
			n++;
		end
		if (!rvalid)
			timeout_error("key port gave no read response");
		data = rdata;
	endtask

	// Column bus from the sticks alone, nothing pressed
	function automatic key_col_t joy_expect(joy_t j0, joy_t j1, logic [1:0] sel_n);
		key_col_t e;
		e = 8'hFF;
		for (int i = 0; i < 4; i++) begin
			if (!sel_n[0] && !j0[i])
				e[i] = 1'b0;
			if (!sel_n[1] && !j1[i])
				e[i] = 1'b0;
		end
		if (!sel_n[0] && !j0[4])
			e[6] = 1'b0;
		if (!sel_n[1] && !j1[4])
			e[7] = 1'b0;
		return e;
	endfunction

	initial begin
		key_ref_t k;
		key_col_t exp_prev;
		key_col_t exp_now;
		cpu_data_t wr;
		cpu_data_t rd;
		scancode_t c;
		joy_t j0;
		joy_t j1;
		int n;
		seed = 32'ha1a2;
		ps2_clk = 1'b1;
		ps2_dat = 1'b1;
		bus = '0;
		joy0 = 5'h1F;
		joy1 = 5'h1F;
		joy_sel_n = 2'b11;
		// A S E W, R D, G H, K L, Q SPACE
		key_tab[0] = '{8'h1C, 3'd1, 3'd2};
		key_tab[1] = '{8'h1B, 3'd1, 3'd5};
		key_tab[2] = '{8'h24, 3'd1, 3'd6};
		key_tab[3] = '{8'h1D, 3'd1, 3'd1};
		key_tab[4] = '{8'h2D, 3'd2, 3'd1};
		key_tab[5] = '{8'h23, 3'd2, 3'd2};
		key_tab[6] = '{8'h34, 3'd3, 3'd2};
		key_tab[7] = '{8'h33, 3'd3, 3'd5};
		key_tab[8] = '{8'h42, 3'd4, 3'd5};
		key_tab[9] = '{8'h4B, 3'd5, 3'd2};
		key_tab[10] = '{8'h15, 3'd7, 3'd6};
		key_tab[11] = '{8'h29, 3'd7, 3'd4};
		n = 0;
		@(posedge CLK28);
		while (!rst_n && (n < 100)) begin
			@(posedge CLK28);
			n++;
		end
		if (!rst_n)
			timeout_error("reset was never released");
		@(negedge CLK28);
		expect_value("kbus", 8'hFF, kbus);
		expect_value("rvalid", 0, rvalid);
		expect_value("key_reset", 0, key_reset);

		// Make, select its row, then break
		repeat (3) begin
			k = key_tab[$unsigned($random(seed)) % NUM_KEYS];
			key_event(1'b0, 1'b0, k.code);
			wr = ~(8'h01 << k.row);
			cpu_write(16'hFD30, wr);
			// Row latch one cycle, kbus register the next
			@(posedge CLK28);
			@(negedge CLK28);
			exp_now = ~(8'h01 << k.col);
			expect_value("kbus", exp_now, kbus);
			key_event(1'b0, 1'b1, k.code);
			@(negedge CLK28);
			expect_value("kbus", 8'hFF, kbus);
		end

		// Same key with broken parity, row still selected
		send_frame(k.code, 1'b1);
		@(negedge CLK28);
		expect_value("kbus", 8'hFF, kbus);

		// Every enable pattern with random stick lines
		for (int s = 0; s < 4; s++) begin
			repeat (4) begin
				j0 = $random(seed);
				j1 = $random(seed);
				exp_prev = joy_expect(joy0, joy1, joy_sel_n);
				exp_now = joy_expect(j0, j1, s[1:0]);
				@(posedge CLK28);
				joy0 <= j0;
				joy1 <= j1;
				joy_sel_n <= s[1:0];
				@(negedge CLK28);
				expect_value("kbus", exp_prev, kbus);
				@(negedge CLK28);
				expect_value("kbus", exp_now, kbus);
			end
		end
		@(posedge CLK28);
		joy0 <= 5'h1F;
		joy1 <= 5'h1F;
		joy_sel_n <= 2'b11;

		// Read back, mirror in page, foreign page ignored
		wr = $random(seed);
		cpu_write(16'hFD35, wr);
		cpu_write(16'hFE30, ~wr);
		cpu_read(16'hFD3A, rd);
		expect_value("rdata", wr, rd);
		cpu_read(16'hC000, rd);
		expect_value("rdata", 8'hFF, rd);

		// Alt is CTRL, Ctrl is C=, E0 71 is DEL
		key_event(1'b0, 1'b0, 8'h11);
		key_event(1'b0, 1'b0, 8'h14);
		@(negedge CLK28);
		expect_value("key_reset", 0, key_reset);
		key_event(1'b1, 1'b0, 8'h71);
		@(negedge CLK28);
		expect_value("key_reset", 1, key_reset);
		for (int i = 0; i < 3; i++) begin
			c = (i == 0) ? 8'h11 : ((i == 1) ? 8'h14 : 8'h71);
			key_event(i == 2, 1'b1, c);
			@(negedge CLK28);
			expect_value("key_reset", 0, key_reset);
			key_event(i == 2, 1'b0, c);
			@(negedge CLK28);
			expect_value("key_reset", 1, key_reset);
		end

		if (fail_cnt == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("SIMULATION FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule

/* src.f */
+incdir+include
design/kbd_pkg.sv
design/ps2_frame_rx.sv
design/key_matrix.sv
design/key_port.sv
design/kbus_drive.sv
design/kbd_top.sv
tb/tb_clk_gen.sv
tb/kbd_tb.sv

/* Bender.yml */
package:
  name: kbd_input

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/kbd_pkg.sv
      - design/ps2_frame_rx.sv
      - design/key_matrix.sv
      - design/key_port.sv
      - design/kbus_drive.sv
      - design/kbd_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clk_gen.sv
      - tb/kbd_tb.sv
